/* verilog/clock_pkg.sv */
package clock_pkg;

	// ----------------------------------------
	// time fields
	// ----------------------------------------
	localparam int FIELD_W = 6;

	localparam int SEC_MAX = 59;
	localparam int MIN_MAX = 59;
	localparam int HR_MAX  = 23;

	// ----------------------------------------
	// modes and field select
	// ----------------------------------------
	localparam logic [1:0] MODE_CLOCK = 2'd0;
	localparam logic [1:0] MODE_SETUP = 2'd1;
	localparam logic [1:0] MODE_ALARM = 2'd2;

	localparam logic [1:0] POS_SEC = 2'd0;
	localparam logic [1:0] POS_MIN = 2'd1;
	localparam logic [1:0] POS_HR  = 2'd2;

	// display: six digits, segments a..g with a on bit 6
	localparam int N_DIGITS = 6;
	localparam int SEG_W    = 7;

	// push buttons
	localparam int N_KEYS    = 4;
	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_STEP  = 2;
	localparam int KEY_ALARM = 3;

endpackage

/* verilog/tick_gen.sv */
`timescale 1ns/1ns

module tick_gen #(
	parameter int DIV = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt; // counts down to zero

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= CNT_W'(DIV - 1);
		end else if (cnt == '0) begin
			cnt <= CNT_W'(DIV - 1);
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign o_tick = (cnt == '0); // one clock per period

endmodule

/* verilog/key_sampler.sv */
`timescale 1ns/1ns

module key_sampler import clock_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [N_KEYS-1:0] i_key,
	input  logic              i_sample,
	output logic [N_KEYS-1:0] o_press
);

	logic [N_KEYS-1:0] smp_new;  // newest sample
	logic [N_KEYS-1:0] smp_old;  // previous sample
	logic              sample_q;

	// ----------------------------------------
	// slow sampling of the button levels
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_new <= '1; // released
			smp_old <= '1;
		end else if (i_sample) begin
			smp_old <= smp_new;
			smp_new <= i_key;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_q <= 1'b0;
		end else begin
			sample_q <= i_sample;
		end
	end

	// high to low between samples, once per sample period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= '0;
		end else begin
			o_press <= {N_KEYS{sample_q}} & smp_old & ~smp_new;
		end
	end

endmodule

/* verilog/mode_ctrl.sv */
`timescale 1ns/1ns

module mode_ctrl import clock_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [N_KEYS-1:0] i_press,
	input  logic              i_sec_tick,
	input  logic              i_sec_wrap,
	input  logic              i_min_wrap,
	output logic [1:0]        o_mode,
	output logic              o_alarm_en,
	output logic [2:0]        o_time_inc,
	output logic [2:0]        o_alarm_inc
);

	logic [1:0] pos;      // selected field
	logic [2:0] step_sel; // step press on the selected field
	logic [2:0] run_inc;  // free running carry chain

	// ----------------------------------------
	// mode, position and alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press[KEY_MODE]) begin
			if (o_mode >= MODE_ALARM) begin
				o_mode <= MODE_CLOCK;
			end else begin
				o_mode <= o_mode + 2'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= POS_SEC;
		end else if (i_press[KEY_POS]) begin
			if (pos >= POS_HR) begin
				pos <= POS_SEC;
			end else begin
				pos <= pos + 2'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press[KEY_ALARM]) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// ----------------------------------------
	// increment routing
	// ----------------------------------------
	assign step_sel = {3{i_press[KEY_STEP]}} & (3'b001 << pos);
	assign run_inc  = {i_min_wrap, i_sec_wrap, i_sec_tick}; // hr, min, sec

	always_comb begin
		case (o_mode)
			MODE_SETUP: begin
				o_time_inc  = step_sel; // time stopped, no carry
				o_alarm_inc = 3'b000;
			end
			MODE_ALARM: begin
				o_time_inc  = run_inc;
				o_alarm_inc = step_sel;
			end
			default: begin
				o_time_inc  = run_inc;
				o_alarm_inc = 3'b000;
			end
		endcase
	end

endmodule

/* verilog/time_counter.sv */
`timescale 1ns/1ns

module time_counter import clock_pkg::*; #(
	parameter int MAX = 59
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_inc,
	output logic [FIELD_W-1:0] o_count,
	output logic               o_wrap
);

	logic at_max;

	assign at_max = (o_count == FIELD_W'(MAX));

	// carry out on the increment that leaves MAX
	assign o_wrap = i_inc & at_max;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (i_inc) begin
			if (at_max) begin
				o_count <= '0;
			end else begin
				o_count <= o_count + 1'b1;
			end
		end
	end

endmodule

/* verilog/timekeeper.sv */
`timescale 1ns/1ns

module timekeeper import clock_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [1:0]         i_mode,
	input  logic               i_alarm_en,
	input  logic [2:0]         i_time_inc,
	input  logic [2:0]         i_alarm_inc,
	output logic [FIELD_W-1:0] o_sec,
	output logic [FIELD_W-1:0] o_min,
	output logic [FIELD_W-1:0] o_hr,
	output logic               o_sec_wrap,
	output logic               o_min_wrap,
	output logic               o_alarm
);

	logic [FIELD_W-1:0] time_sec;
	logic [FIELD_W-1:0] time_min;
	logic [FIELD_W-1:0] time_hr;
	logic [FIELD_W-1:0] alarm_sec;
	logic [FIELD_W-1:0] alarm_min;
	logic [FIELD_W-1:0] alarm_hr;
	logic               match;

	// ----------------------------------------
	// running time
	// ----------------------------------------
	time_counter #(.MAX(SEC_MAX)) u_sec (
		.clk     ( clk           ),
		.rst_n   ( rst_n         ),
		.i_inc   ( i_time_inc[0] ),
		.o_count ( time_sec      ),
		.o_wrap  ( o_sec_wrap    )
	);

	time_counter #(.MAX(MIN_MAX)) u_min (
		.clk     ( clk           ),
		.rst_n   ( rst_n         ),
		.i_inc   ( i_time_inc[1] ),
		.o_count ( time_min      ),
		.o_wrap  ( o_min_wrap    )
	);

	time_counter #(.MAX(HR_MAX)) u_hr (
		.clk     ( clk           ),
		.rst_n   ( rst_n         ),
		.i_inc   ( i_time_inc[2] ),
		.o_count ( time_hr       ),
		.o_wrap  (               )  // day rollover not needed
	);

	// ----------------------------------------
	// alarm setting
	// ----------------------------------------
	time_counter #(.MAX(SEC_MAX)) u_alarm_sec (
		.clk     ( clk            ),
		.rst_n   ( rst_n          ),
		.i_inc   ( i_alarm_inc[0] ),
		.o_count ( alarm_sec      ),
		.o_wrap  (                )
	);

	time_counter #(.MAX(MIN_MAX)) u_alarm_min (
		.clk     ( clk            ),
		.rst_n   ( rst_n          ),
		.i_inc   ( i_alarm_inc[1] ),
		.o_count ( alarm_min      ),
		.o_wrap  (                )
	);

	time_counter #(.MAX(HR_MAX)) u_alarm_hr (
		.clk     ( clk            ),
		.rst_n   ( rst_n          ),
		.i_inc   ( i_alarm_inc[2] ),
		.o_count ( alarm_hr       ),
		.o_wrap  (                )
	);

	// alarm values only while setting them
	assign o_sec = (i_mode == MODE_ALARM) ? alarm_sec : time_sec;
	assign o_min = (i_mode == MODE_ALARM) ? alarm_min : time_min;
	assign o_hr  = (i_mode == MODE_ALARM) ? alarm_hr  : time_hr;

	assign match = (time_sec == alarm_sec) && (time_min == alarm_min) && (time_hr == alarm_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (match | o_alarm); // sticky until disabled
		end
	end

endmodule

/* verilog/seg_scan.sv */
`timescale 1ns/1ns

module seg_scan import clock_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_scan,
	input  logic [FIELD_W-1:0]  i_sec,
	input  logic [FIELD_W-1:0]  i_min,
	input  logic [FIELD_W-1:0]  i_hr,
	output logic [SEG_W-1:0]    o_seg,
	output logic [N_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W = $clog2(N_DIGITS);

	logic [IDX_W-1:0] scan_idx;
	logic [3:0]       sec_tens;
	logic [3:0]       sec_ones;
	logic [3:0]       min_tens;
	logic [3:0]       min_ones;
	logic [3:0]       hr_tens;
	logic [3:0]       hr_ones;
	logic [3:0]       digit;

	// active high, {a, b, c, d, e, f, g}
	function automatic logic [SEG_W-1:0] seg_decode(input logic [3:0] num);
		logic [SEG_W-1:0] seg;
		case (num)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			default: seg = 7'b000_0000; // blank
		endcase
		return seg;
	endfunction

	// ----------------------------------------
	// tens and ones
	// ----------------------------------------
	assign sec_tens = 4'(i_sec / 10);
	assign sec_ones = 4'(i_sec % 10);
	assign min_tens = 4'(i_min / 10);
	assign min_ones = 4'(i_min % 10);
	assign hr_tens  = 4'(i_hr / 10);
	assign hr_ones  = 4'(i_hr % 10);

	// ----------------------------------------
	// digit scan
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan) begin
			if (scan_idx == IDX_W'(N_DIGITS - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	always_comb begin
		case (scan_idx)
			3'd0:    digit = sec_ones;
			3'd1:    digit = sec_tens;
			3'd2:    digit = min_ones;
			3'd3:    digit = min_tens;
			3'd4:    digit = hr_ones;
			3'd5:    digit = hr_tens;
			default: digit = 4'hf;
		endcase
	end

	assign o_seg     = seg_decode(digit);
	assign o_seg_enb = ~(N_DIGITS'(1) << scan_idx); // one cold

endmodule

/* verilog/alarm_clock_top.sv */
`timescale 1ns/1ns

module alarm_clock_top import clock_pkg::*; #(
	parameter int SEC_DIV  = 50_000_000, // 1 Hz from 50 MHz
	parameter int SCAN_DIV = 50_000,
	parameter int KEY_DIV  = 500_000     // 100 Hz button sampling
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [N_KEYS-1:0]   i_key,
	output logic [SEG_W-1:0]    o_seg,
	output logic [N_DIGITS-1:0] o_seg_enb,
	output logic                o_alarm
);

	logic               sec_tick;
	logic               scan_tick;
	logic               key_tick;
	logic [N_KEYS-1:0]  press;
	logic [1:0]         mode;
	logic               alarm_en;
	logic [2:0]         time_inc;
	logic [2:0]         alarm_inc;
	logic [FIELD_W-1:0] disp_sec;
	logic [FIELD_W-1:0] disp_min;
	logic [FIELD_W-1:0] disp_hr;
	logic               sec_wrap;
	logic               min_wrap;

	// ----------------------------------------
	// clock enables
	// ----------------------------------------
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(KEY_DIV))  u_key_tick  (.clk(clk), .rst_n(rst_n), .o_tick(key_tick));

	key_sampler u_key_sampler (
		.clk      ( clk      ),
		.rst_n    ( rst_n    ),
		.i_key    ( i_key    ),
		.i_sample ( key_tick ),
		.o_press  ( press    )
	);

	mode_ctrl u_mode_ctrl (
		.clk         ( clk       ),
		.rst_n       ( rst_n     ),
		.i_press     ( press     ),
		.i_sec_tick  ( sec_tick  ),
		.i_sec_wrap  ( sec_wrap  ),
		.i_min_wrap  ( min_wrap  ),
		.o_mode      ( mode      ),
		.o_alarm_en  ( alarm_en  ),
		.o_time_inc  ( time_inc  ),
		.o_alarm_inc ( alarm_inc )
	);

	timekeeper u_timekeeper (
		.clk         ( clk       ),
		.rst_n       ( rst_n     ),
		.i_mode      ( mode      ),
		.i_alarm_en  ( alarm_en  ),
		.i_time_inc  ( time_inc  ),
		.i_alarm_inc ( alarm_inc ),
		.o_sec       ( disp_sec  ),
		.o_min       ( disp_min  ),
		.o_hr        ( disp_hr   ),
		.o_sec_wrap  ( sec_wrap  ),
		.o_min_wrap  ( min_wrap  ),
		.o_alarm     ( o_alarm   )
	);

	seg_scan u_seg_scan (
		.clk       ( clk       ),
		.rst_n     ( rst_n     ),
		.i_scan    ( scan_tick ),
		.i_sec     ( disp_sec  ),
		.i_min     ( disp_min  ),
		.i_hr      ( disp_hr   ),
		.o_seg     ( o_seg     ),
		.o_seg_enb ( o_seg_enb )
	);

endmodule

/* tb/alarm_clock_sva.sv */
`timescale 1ns/1ns

module alarm_clock_sva import clock_pkg::*; (
	input logic                clk,
	input logic                rst_n,
	input logic [N_KEYS-1:0]   i_key,
	input logic [SEG_W-1:0]    o_seg,
	input logic [N_DIGITS-1:0] o_seg_enb,
	input logic                o_alarm
);

	logic alarm_key_seen;  // alarm button went low since reset
	int   fail_count = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_key_seen <= 1'b0;
		end else if (!i_key[KEY_ALARM]) begin
			alarm_key_seen <= 1'b1;
		end
	end

	// ----------------------------------------
	// display and alarm output
	// ----------------------------------------
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb))
	else begin
		$error("o_seg_enb does not have exactly one low bit");
		fail_count++;
	end

	a_alarm_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!alarm_key_seen |-> !o_alarm)
	else begin
		$error("o_alarm high before the alarm key was pressed");
		fail_count++;
	end

	// patterns for 0 to 9, a on bit 6
	a_seg_digit: assert property (@(posedge clk) disable iff (!rst_n)
		(o_seg_enb != '1) |-> (o_seg inside {7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		                                     7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73}))
	else begin
		$error("o_seg is not a digit pattern while a digit is enabled");
		fail_count++;
	end

endmodule

bind alarm_clock_top alarm_clock_sva i_sva (
	.clk       ( clk       ),
	.rst_n     ( rst_n     ),
	.i_key     ( i_key     ),
	.o_seg     ( o_seg     ),
	.o_seg_enb ( o_seg_enb ),
	.o_alarm   ( o_alarm   )
);

/* tb/alarm_clock_tb.sv */
`timescale 1ns/1ns

module alarm_clock_tb import clock_pkg::*; ();

	localparam int SEC_DIV     = 600;
	localparam int SCAN_DIV    = 4;
	localparam int KEY_DIV     = 8;
	localparam int PRESS_CYC   = 8 * KEY_DIV;  // 4 sample periods low, 4 high
	localparam int N_PRESSES   = 500;          // upper bound over all tests
	localparam int N_SECONDS   = 120;          // waits, captures and alarm lead
	localparam int TIMEOUT_CYC = N_PRESSES * PRESS_CYC + N_SECONDS * SEC_DIV;

	logic                clk;
	logic                rst_n;
	logic [N_KEYS-1:0]   i_key;
	logic [SEG_W-1:0]    o_seg;
	logic [N_DIGITS-1:0] o_seg_enb;
	logic                o_alarm;

	logic [31:0] lfsr;
	int          cyc;        // clocks since reset release
	int          m_mode;
	int          m_pos;
	int          m_en;
	int          m_flag;     // model of o_alarm
	int          m_time[3];  // sec, min, hr
	int          m_alm[3];
	int          d_sec;
	int          d_min;
	int          d_hr;
	int          d_seen;     // digits whose enable went low

	alarm_clock_top #(
		.SEC_DIV  ( SEC_DIV  ),
		.SCAN_DIV ( SCAN_DIV ),
		.KEY_DIV  ( KEY_DIV  )
	) i_dut (
		.clk       ( clk       ),
		.rst_n     ( rst_n     ),
		.i_key     ( i_key     ),
		.o_seg     ( o_seg     ),
		.o_seg_enb ( o_seg_enb ),
		.o_alarm   ( o_alarm   )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	function automatic int field_max(input int p);
		return (p == POS_HR) ? HR_MAX : ((p == POS_MIN) ? MIN_MAX : SEC_MAX);
	endfunction

	function automatic int bump(input int v, input int p);
		return (v == field_max(p)) ? 0 : v + 1;
	endfunction

	// what the display should show for field p
	function automatic int exp_field(input int p);
		return (m_mode == MODE_ALARM) ? m_alm[p] : m_time[p];
	endfunction

	function automatic int seg_digit(input logic [SEG_W-1:0] seg);
		case (seg)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 99; // not a digit
		endcase
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// model clock, second tick and timeout
	always @(posedge clk) begin
		if (rst_n) begin
			cyc = cyc + 1;
			// flag follows the match by one clock
			m_flag = m_en && (m_flag || (m_time[0] == m_alm[0] &&
				m_time[1] == m_alm[1] && m_time[2] == m_alm[2]));
			if (cyc % SEC_DIV == 0 && m_mode != MODE_SETUP) begin
				m_time[0] = bump(m_time[0], 0);
				if (m_time[0] == 0) begin
					m_time[1] = bump(m_time[1], 1);
					if (m_time[1] == 0) begin
						m_time[2] = bump(m_time[2], 2);
					end
				end
			end
			if (cyc >= TIMEOUT_CYC) begin
				$display("** Error at %0t ns: timeout, tests still running after %0d cycles",
					$time, cyc);
				$display("Test failures found");
				$fatal(1, "simulation timed out");
			end
		end
	end

	// keep clear of second boundaries
	task automatic wait_safe();
		while ((cyc % SEC_DIV) < 2 || (cyc % SEC_DIV) > SEC_DIV - 40) begin
			@(negedge clk);
		end
	endtask

	task automatic press_key(input int key);
		if (key == KEY_MODE || key == KEY_ALARM) begin
			wait_safe();
		end
		case (key)
			KEY_MODE:  m_mode = (m_mode == MODE_ALARM) ? MODE_CLOCK : m_mode + 1;
			KEY_POS:   m_pos = (m_pos == POS_HR) ? POS_SEC : m_pos + 1;
			KEY_ALARM: m_en = !m_en;
			default: begin
				if (m_mode == MODE_SETUP) begin
					m_time[m_pos] = bump(m_time[m_pos], m_pos); // no carry
				end else if (m_mode == MODE_ALARM) begin
					m_alm[m_pos] = bump(m_alm[m_pos], m_pos);
				end
			end
		endcase
		i_key[key] = 1'b0;
		repeat (4 * KEY_DIV) @(negedge clk);
		i_key[key] = 1'b1;
		repeat (4 * KEY_DIV) @(negedge clk);
	endtask

	task automatic select_pos(input int p);
		while (m_pos != p) begin
			press_key(KEY_POS);
		end
	endtask

	task automatic step_to(input int p, input int target);
		int n;
		select_pos(p);
		n = (target - exp_field(p) + field_max(p) + 1) % (field_max(p) + 1);
		repeat (n) press_key(KEY_STEP);
	endtask

	// one full scan of six digits
	task automatic capture();
		int digit[N_DIGITS];
		int k;
		d_seen = 0;
		for (k = 0; k < N_DIGITS; k++) begin
			digit[k] = 99;
		end
		repeat (N_DIGITS * SCAN_DIV) begin
			for (k = 0; k < N_DIGITS; k++) begin
				if (o_seg_enb[k] == 1'b0) begin
					digit[k] = seg_digit(o_seg);
					d_seen   = d_seen | (1 << k);
				end
			end
			@(negedge clk);
		end
		d_sec = digit[1] * 10 + digit[0];
		d_min = digit[3] * 10 + digit[2];
		d_hr  = digit[5] * 10 + digit[4];
	endtask

	task automatic check_display(input string what);
		wait_safe();
		capture();
		check_value({what, ", seconds"}, d_sec, exp_field(0));
		check_value({what, ", minutes"}, d_min, exp_field(1));
		check_value({what, ", hours"}, d_hr, exp_field(2));
	endtask

	task automatic random_presses(input string what);
		int b;
		int n;
		repeat (6) begin
			take_bits(1, b);
			if (b != 0) begin
				press_key(KEY_POS);
			end
			take_bits(2, n);
			repeat (n + 1) press_key(KEY_STEP);
			check_display(what);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int i;
		int min_before;
		int total;
		int t_sec;
		int t_min;
		int t_hr;

		rst_n  = 1'b0;
		i_key  = '1;
		lfsr   = 32'hd353_c41d;
		cyc    = 0;
		m_mode = MODE_CLOCK;
		m_pos  = POS_SEC;
		m_en   = 0;
		m_flag = 0;
		for (i = 0; i < 3; i++) begin
			m_time[i] = 0;
			m_alm[i]  = 0;
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// after reset
		capture();
		check_value("seconds after reset", d_sec, 0);
		check_value("minutes after reset", d_min, 0);
		check_value("hours after reset", d_hr, 0);
		check_value("digits scanned", d_seen, 6'h3f);
		check_value("o_alarm after reset", o_alarm, m_flag);

		repeat (4) begin
			repeat (SEC_DIV) @(negedge clk);
			check_display("clock mode");
		end

		// setup mode, then 23:59:55
		press_key(KEY_MODE);
		random_presses("setup steps");
		select_pos(POS_SEC);
		min_before = m_time[1];
		repeat (field_max(POS_SEC) + 1 - m_time[0]) press_key(KEY_STEP);
		check_display("seconds wrap in setup");
		check_value("seconds after wrap", d_sec, 0);
		check_value("minutes after seconds wrap", d_min, min_before);
		step_to(POS_SEC, 55);
		step_to(POS_MIN, 59);
		step_to(POS_HR, 23);
		check_display("setup to 23:59:55");

		// through alarm-set back to clock, wait for the day rollover
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		i = 0;
		check_display("before rollover");
		while (!(d_hr == 0 && d_min == 0) && i < 12) begin
			repeat (SEC_DIV) @(negedge clk);
			check_display("rollover");
			i++;
		end
		check_value("hours after rollover", d_hr, 0);
		check_value("minutes after rollover", d_min, 0);
		check_value("seconds tens after rollover", d_sec / 10, 0);

		// alarm-set mode
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		random_presses("alarm steps");
		press_key(KEY_MODE);
		check_display("clock after alarm set");

		// alarm 30 s ahead
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		total = m_time[2] * 3600 + m_time[1] * 60 + m_time[0] + 30;
		total = total % 86400;
		t_hr  = total / 3600;
		t_min = (total / 60) % 60;
		t_sec = total % 60;
		step_to(POS_SEC, t_sec);
		step_to(POS_MIN, t_min);
		step_to(POS_HR, t_hr);
		check_display("alarm target");
		press_key(KEY_MODE);
		press_key(KEY_ALARM);
		check_value("o_alarm before match", o_alarm, m_flag);
		i = 0;
		while (!o_alarm && i < 45 * SEC_DIV) begin
			@(negedge clk);
			i++;
		end
		check_value("o_alarm at match", o_alarm, m_flag);
		capture();
		check_value("seconds at alarm", d_sec, t_sec);
		check_value("minutes at alarm", d_min, t_min);
		check_value("hours at alarm", d_hr, t_hr);
		repeat (2 * SEC_DIV) @(negedge clk);
		check_value("o_alarm held", o_alarm, m_flag);
		press_key(KEY_ALARM);
		check_value("o_alarm after disable", o_alarm, m_flag);
		check_display("clock after alarm");

		if (i_dut.i_sva.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "concurrent assertions failed %0d times", i_dut.i_sva.fail_count);
		end
	end

endmodule

/* sources.f */
verilog/clock_pkg.sv
verilog/tick_gen.sv
verilog/key_sampler.sv
verilog/mode_ctrl.sv
verilog/time_counter.sv
verilog/timekeeper.sv
verilog/seg_scan.sv
verilog/alarm_clock_top.sv
tb/alarm_clock_sva.sv
tb/alarm_clock_tb.sv
